// ==== include/ctl_consts.svh ====
`ifndef CTL_CONSTS_SVH
`define CTL_CONSTS_SVH

`define CTL_DB_W      8
`define CTL_AB_OP_W   12
`define CTL_ALU_OP_W  9
`define CTL_REG_OP_W  7
`define CTL_DO_OP_W   2

// Supported opcodes
`define OP_BRK        8'h00
`define OP_ASL_ZP     8'h06
`define OP_ASL_ZPX    8'h16
`define OP_JSR        8'h20
`define OP_RTI        8'h40
`define OP_PHA        8'h48
`define OP_JMP_ABS    8'h4C
`define OP_RTS        8'h60
`define OP_PLA        8'h68
`define OP_JMP_IND    8'h6C
`define OP_JMP_INDX   8'h7C
`define OP_BRA        8'h80
`define OP_LDY_IMM    8'hA0
`define OP_LDA_INDX   8'hA1
`define OP_LDX_IMM    8'hA2
`define OP_LDA_ZP     8'hA5
`define OP_LDA_IMM    8'hA9
`define OP_LDA_ABS    8'hAD
`define OP_LDA_INDY   8'hB1
`define OP_LDA_IND    8'hB2
`define OP_LDA_ZPX    8'hB5
`define OP_LDX_ZPY    8'hB6
`define OP_LDA_ABSY   8'hB9
`define OP_LDA_ABSX   8'hBD
`define OP_DEX        8'hCA
`define OP_INC_ZP     8'hE6
`define OP_INX        8'hE8
`define OP_INC_ABS    8'hEE

`define REG_OP_STACK  7'b1_11_0011    // Write S
`define REG_OP_IDLE   7'b0_00_0111    // Read Z, no write
`define ALU_DEC       9'b00_00_101_00
`define ALU_INC       9'b00_00_100_01
`define ALU_LOAD_M    9'b10_00_000_00
`define AB_OP_BRANCH_BACK 12'b011_0111_11_11_1
`define AB_OP_BRANCH_FWD  12'b011_0110_11_11_1

`endif

// ==== logic/ctl_pkg.sv ====
package ctl_pkg;

    // Cycle sequencer states
    typedef enum logic [5:0] {
        INIT, SYNC, IMM0,                   // Fetch and immediate
        IND0, IND1, IND2, DATA,             // Zero page indirect, data access
        ABS0, ABS1, ZERO,                   // Absolute and zero page address
        PULL, RDWR,                         // Stack pull, RMW hold
        RTS0, RTS1, RTS2,
        PUSH,
        JSR0, JSR1, JSR2,
        BRK0, BRK1, BRK2, BRK3,
        RTI0, RTI1, RTI2, RTI3,
        COND                                // Branch offset cycle
    } ctl_state_t;

    // Register file source index
    typedef enum logic [3:0] {
        SRC_X   = 4'd0,
        SRC_Y   = 4'd1,
        SRC_A   = 4'd2,
        SRC_S   = 4'd3,
        SRC_M   = 4'd5,                     // Memory operand
        SRC_Z   = 4'd7,                     // Zero
        SRC_VEC = 4'd10                     // Interrupt vector
    } reg_src_t;

    // Register file destination index
    typedef enum logic [1:0] {
        DST_X, DST_Y, DST_A, DST_S
    } reg_dst_t;

    // Latched ALU field
    typedef struct packed {
        logic [1:0] shift;                  // 10 left, 11 right
        logic [2:0] add;                    // OR AND XOR ADD INC DEC SUB TRB
        logic [1:0] carry;                  // 01 one, 10 rot, 11 adc
    } alu_sel_t;

    // Address datapath mode, bit 2 is ABL carry, bits 1:0 the ABL mux
    typedef enum logic [3:0] {
        AB_KEEP = 4'd0,  AB_PC = 4'd1,      AB_ABS = 4'd2,      AB_ZP = 4'd3,
        AB_NEXT = 4'd4,  AB_SP_INC = 4'd5,  AB_BRANCH = 4'd7,   AB_SP_KEEP = 4'd8,
        AB_SP_SAVE = 4'd9,  AB_ABS_KEEP = 4'd10, AB_SP = 4'd11, AB_NEXT_KEEP = 4'd12,
        AB_ABS_INC = 4'd14, AB_VECTOR = 4'd15
    } ab_mode_t;

endpackage

// ==== logic/opcode_decoder.sv ====
`timescale 1ns/1ps
`include "ctl_consts.svh"

module opcode_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`CTL_DB_W-1:0] db,
    input  logic                 sync,
    input  logic                 addr_done,
    output logic                 rmw,
    output logic                 jmp,
    output logic                 ind,
    output logic                 add_x,
    output logic                 add_y,
    output logic                 ld,
    output logic                 st,
    output ctl_pkg::reg_src_t    src,
    output ctl_pkg::reg_dst_t    dst,
    output ctl_pkg::alu_sel_t    alu
);

    always_ff @(posedge clk) begin
        if (rst) begin
            rmw   <= 1'b0;
            jmp   <= 1'b0;
            ind   <= 1'b0;
            add_x <= 1'b0;
            add_y <= 1'b0;
            ld    <= 1'b0;
            st    <= 1'b0;
            src   <= ctl_pkg::SRC_X;
            dst   <= ctl_pkg::DST_X;
            alu   <= '0;
        end else if (sync) begin
            rmw   <= 1'b0;                      // Defaults, overridden per opcode
            jmp   <= 1'b0;
            ind   <= 1'b0;
            add_x <= 1'b0;
            add_y <= 1'b0;
            ld    <= 1'b0;
            st    <= 1'b0;
            src   <= ctl_pkg::SRC_Z;
            dst   <= ctl_pkg::DST_A;
            alu   <= '0;
            case (db)
                `OP_LDA_IMM, `OP_LDA_ZP, `OP_LDA_ABS, `OP_LDA_IND, `OP_PLA: begin
                    ld  <= 1'b1;                // A <= Z + M
                    alu <= 7'b00_011_00;
                end
                `OP_LDA_ZPX, `OP_LDA_ABSX, `OP_LDA_INDX: begin
                    ld    <= 1'b1;
                    add_x <= 1'b1;              // X indexed
                    alu   <= 7'b00_011_00;
                end
                `OP_LDA_INDY, `OP_LDA_ABSY: begin
                    ld    <= 1'b1;
                    add_y <= 1'b1;              // Y indexed
                    alu   <= 7'b00_011_00;
                end
                `OP_LDX_IMM, `OP_LDY_IMM, `OP_LDX_ZPY: begin
                    ld    <= 1'b1;
                    add_y <= (db == `OP_LDX_ZPY);
                    dst   <= (db == `OP_LDY_IMM) ? ctl_pkg::DST_Y : ctl_pkg::DST_X;
                    alu   <= 7'b00_011_00;
                end
                `OP_DEX, `OP_INX: begin
                    ld  <= 1'b1;                // X <= X -/+ 1
                    src <= ctl_pkg::SRC_X;
                    dst <= ctl_pkg::DST_X;
                    alu <= (db == `OP_DEX) ? 7'b00_101_00 : 7'b00_100_01;
                end
                `OP_PHA: begin
                    st  <= 1'b1;
                    src <= ctl_pkg::SRC_A;
                    alu <= 7'b00_011_00;
                end
                `OP_ASL_ZP, `OP_ASL_ZPX: begin
                    rmw   <= (db == `OP_ASL_ZP);   // ZP,X takes the short path
                    add_x <= (db == `OP_ASL_ZPX);
                    src   <= ctl_pkg::SRC_M;
                    alu   <= 7'b10_000_00;         // Shift left
                end
                `OP_INC_ZP, `OP_INC_ABS: begin
                    rmw <= 1'b1;
                    src <= ctl_pkg::SRC_M;
                    alu <= 7'b00_100_01;           // M + 1
                end
                `OP_BRK, `OP_JSR, `OP_RTI, `OP_RTS, `OP_JMP_ABS: begin
                    jmp <= 1'b1;
                end
                `OP_JMP_IND, `OP_JMP_INDX: begin
                    jmp   <= 1'b1;
                    ind   <= 1'b1;
                    add_x <= (db == `OP_JMP_INDX);
                end
                default: begin
                end
            endcase
        end else if (addr_done) begin
            // One indirection only, else JMP (IND) loops through ABS0
            ind   <= 1'b0;
            add_x <= 1'b0;
        end
    end

endmodule

// ==== logic/cycle_sequencer.sv ====
`timescale 1ns/1ps
`include "ctl_consts.svh"

module cycle_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`CTL_DB_W-1:0] db,
    input  logic                 rmw,
    input  logic                 jmp,
    input  logic                 ind,
    output ctl_pkg::ctl_state_t  state,
    output logic                 sync,
    output logic                 we,
    output logic                 addr_done
);

    ctl_pkg::ctl_state_t state_next;

    assign sync      = (state == ctl_pkg::SYNC);
    assign addr_done = (state == ctl_pkg::ABS1);

    always_comb begin
        state_next = ctl_pkg::SYNC;             // Unknown opcode stays in SYNC
        case (state)
            ctl_pkg::SYNC: begin
                case (db)
                    `OP_BRA:      state_next = ctl_pkg::COND;
                    `OP_BRK:      state_next = ctl_pkg::BRK0;
                    `OP_JSR:      state_next = ctl_pkg::JSR0;
                    `OP_RTI:      state_next = ctl_pkg::RTI0;
                    `OP_RTS:      state_next = ctl_pkg::RTS0;
                    `OP_PHA:      state_next = ctl_pkg::PUSH;
                    `OP_PLA:      state_next = ctl_pkg::PULL;
                    `OP_JMP_ABS, `OP_JMP_IND, `OP_JMP_INDX,
                    `OP_LDA_ABS, `OP_LDA_ABSX, `OP_LDA_ABSY,
                    `OP_INC_ABS:  state_next = ctl_pkg::ABS0;
                    `OP_ASL_ZP, `OP_ASL_ZPX, `OP_LDA_ZP, `OP_LDA_ZPX,
                    `OP_LDX_ZPY, `OP_INC_ZP:
                                  state_next = ctl_pkg::ZERO;
                    `OP_LDA_INDX, `OP_LDA_IND, `OP_LDA_INDY:
                                  state_next = ctl_pkg::IND0;
                    `OP_LDA_IMM, `OP_LDX_IMM, `OP_LDY_IMM:
                                  state_next = ctl_pkg::IMM0;
                    default:      state_next = ctl_pkg::SYNC;
                endcase
            end
            ctl_pkg::IND0: state_next = ctl_pkg::IND1;
            ctl_pkg::IND1: state_next = ctl_pkg::IND2;
            ctl_pkg::IND2: state_next = ctl_pkg::DATA;
            ctl_pkg::ABS0: state_next = ctl_pkg::ABS1;
            ctl_pkg::ZERO: state_next = rmw ? ctl_pkg::RDWR : ctl_pkg::DATA;
            ctl_pkg::ABS1: begin
                if (ind)      state_next = ctl_pkg::ABS0;   // Fetch pointer target
                else if (jmp) state_next = ctl_pkg::SYNC;
                else if (rmw) state_next = ctl_pkg::RDWR;
                else          state_next = ctl_pkg::DATA;
            end
            ctl_pkg::RDWR, ctl_pkg::PULL, ctl_pkg::PUSH:
                           state_next = ctl_pkg::DATA;
            ctl_pkg::RTS0: state_next = ctl_pkg::RTS1;
            ctl_pkg::RTS1: state_next = ctl_pkg::RTS2;
            ctl_pkg::JSR0: state_next = ctl_pkg::JSR1;
            ctl_pkg::JSR1: state_next = ctl_pkg::JSR2;
            ctl_pkg::JSR2: state_next = ctl_pkg::ABS1;      // Target high byte
            ctl_pkg::BRK0: state_next = ctl_pkg::BRK1;
            ctl_pkg::BRK1: state_next = ctl_pkg::BRK2;
            ctl_pkg::BRK2: state_next = ctl_pkg::BRK3;
            ctl_pkg::BRK3: state_next = ctl_pkg::ABS0;      // Vector fetch
            ctl_pkg::RTI0: state_next = ctl_pkg::RTI1;
            ctl_pkg::RTI1: state_next = ctl_pkg::RTI2;
            ctl_pkg::RTI2: state_next = ctl_pkg::RTI3;
            default:       state_next = ctl_pkg::SYNC;      // INIT, IMM0, DATA, RTS2, RTI3, COND
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ctl_pkg::INIT;
            we    <= 1'b0;
        end else begin
            state <= state_next;
            we    <= (state inside {ctl_pkg::BRK0, ctl_pkg::BRK1, ctl_pkg::BRK2,
                                    ctl_pkg::JSR0, ctl_pkg::JSR1,
                                    ctl_pkg::PUSH, ctl_pkg::RDWR});  // Write next cycle
        end
    end

endmodule

// ==== logic/micro_op_encoder.sv ====
`timescale 1ns/1ps
`include "ctl_consts.svh"

module micro_op_encoder (
    input  ctl_pkg::ctl_state_t        state,
    input  logic                       ld,
    input  logic                       st,
    input  logic                       add_x,
    input  logic                       add_y,
    input  ctl_pkg::reg_src_t          src,
    input  ctl_pkg::reg_dst_t          dst,
    input  ctl_pkg::alu_sel_t          alu,
    output logic [`CTL_REG_OP_W-1:0]   reg_op,
    output logic [`CTL_ALU_OP_W-1:0]   alu_op,
    output logic [`CTL_DO_OP_W-1:0]    do_op
);

    logic [3:0] idx_xy;                         // Index for ZERO and ABS1

    assign idx_xy = add_x ? ctl_pkg::SRC_X : add_y ? ctl_pkg::SRC_Y : ctl_pkg::SRC_Z;

    // reg_op is {write, dst, src}
    always_comb begin
        case (state)
            ctl_pkg::BRK0, ctl_pkg::BRK1, ctl_pkg::BRK2, ctl_pkg::JSR0, ctl_pkg::JSR1,
            ctl_pkg::RTS0, ctl_pkg::RTS1, ctl_pkg::RTI0, ctl_pkg::RTI1, ctl_pkg::RTI2,
            ctl_pkg::PUSH, ctl_pkg::PULL:
                reg_op = `REG_OP_STACK;
            ctl_pkg::BRK3: reg_op = {3'b000, ctl_pkg::SRC_VEC};
            ctl_pkg::IND0: reg_op = {3'b000, add_x ? ctl_pkg::SRC_X : ctl_pkg::SRC_Z};
            ctl_pkg::IND2: reg_op = {3'b000, add_y ? ctl_pkg::SRC_Y : ctl_pkg::SRC_Z};
            ctl_pkg::ZERO, ctl_pkg::ABS1:
                           reg_op = {3'b000, idx_xy};
            ctl_pkg::SYNC: reg_op = {ld, dst, src};        // Write-back of last instruction
            ctl_pkg::DATA: reg_op = {1'b0, dst, src};      // Operand for store
            default:       reg_op = `REG_OP_IDLE;
        endcase
    end

    // alu_op is {ldm, bcd, shift, add, carry}
    always_comb begin
        case (state)
            ctl_pkg::BRK0, ctl_pkg::BRK1, ctl_pkg::BRK2, ctl_pkg::JSR0, ctl_pkg::JSR1,
            ctl_pkg::PUSH:
                alu_op = `ALU_DEC;                          // S - 1
            ctl_pkg::RTS0, ctl_pkg::RTS1, ctl_pkg::RTI0, ctl_pkg::RTI1, ctl_pkg::RTI2,
            ctl_pkg::PULL:
                alu_op = `ALU_INC;                          // S + 1
            ctl_pkg::IMM0, ctl_pkg::RDWR:
                alu_op = `ALU_LOAD_M;
            ctl_pkg::SYNC:
                alu_op = {2'b00, alu};
            ctl_pkg::DATA:
                alu_op = st ? 9'b00_00_100_00 : {2'b10, alu};   // Store or load M
            default:
                alu_op = '0;
        endcase
    end

    // Data out: 00 ALU, 01 P, 10 PCL, 11 PCH
    always_comb begin
        case (state)
            ctl_pkg::BRK1, ctl_pkg::JSR1: do_op = 2'b11;
            ctl_pkg::BRK2, ctl_pkg::JSR2: do_op = 2'b10;
            ctl_pkg::BRK3:                do_op = 2'b01;
            default:                      do_op = 2'b00;
        endcase
    end

endmodule

// ==== logic/addr_mode_encoder.sv ====
`timescale 1ns/1ps
`include "ctl_consts.svh"

module addr_mode_encoder (
    input  ctl_pkg::ctl_state_t       state,
    input  logic                      cond,
    input  logic [`CTL_DB_W-1:0]      db,
    output logic [`CTL_AB_OP_W-1:0]   ab_op
);

    ctl_pkg::ab_mode_t mode;
    logic              back;                // Taken backward branch
    logic [1:0]        abl_sel;
    logic              abl_ci;

    assign back    = cond & db[7];
    assign abl_sel = mode[1:0];
    assign abl_ci  = mode[2];

    always_comb begin
        case (state)
            ctl_pkg::DATA, ctl_pkg::JSR2:                 mode = ctl_pkg::AB_PC;
            ctl_pkg::SYNC, ctl_pkg::ABS0, ctl_pkg::IMM0:  mode = ctl_pkg::AB_NEXT;
            ctl_pkg::ABS1, ctl_pkg::RTI3:                 mode = ctl_pkg::AB_ABS;
            ctl_pkg::IND0, ctl_pkg::ZERO:                 mode = ctl_pkg::AB_ZP;
            ctl_pkg::IND1:                                mode = ctl_pkg::AB_NEXT_KEEP;
            ctl_pkg::IND2:                                mode = ctl_pkg::AB_ABS_KEEP;
            ctl_pkg::PULL, ctl_pkg::RTS0, ctl_pkg::RTS1,
            ctl_pkg::RTI0, ctl_pkg::RTI1, ctl_pkg::RTI2:  mode = ctl_pkg::AB_SP_INC;
            ctl_pkg::PUSH:                                mode = ctl_pkg::AB_SP;
            ctl_pkg::RTS2:                                mode = ctl_pkg::AB_ABS_INC;
            ctl_pkg::JSR0, ctl_pkg::BRK0:                 mode = ctl_pkg::AB_SP_SAVE;
            ctl_pkg::JSR1, ctl_pkg::BRK1, ctl_pkg::BRK2:  mode = ctl_pkg::AB_SP_KEEP;
            ctl_pkg::BRK3:                                mode = ctl_pkg::AB_VECTOR;
            ctl_pkg::COND:                                mode = ctl_pkg::AB_BRANCH;
            default:                                      mode = ctl_pkg::AB_KEEP;  // INIT, RDWR
        endcase
    end

    // ab_op is {PC and ABH control, ABL sel, ABL op, ABL carry}
    always_comb begin
        case (mode)
            ctl_pkg::AB_KEEP:      ab_op = {7'b001_0110, abl_sel, 2'b11, abl_ci};
            ctl_pkg::AB_PC:        ab_op = {7'b000_1010, abl_sel, 2'b10, abl_ci};
            ctl_pkg::AB_ABS:       ab_op = {7'b111_1110, abl_sel, 2'b01, abl_ci};
            ctl_pkg::AB_ZP:        ab_op = {7'b111_0000, abl_sel, 2'b01, abl_ci};  // {00, DB+REG}
            ctl_pkg::AB_NEXT:      ab_op = {7'b011_0110, abl_sel, 2'b11, abl_ci};  // AB + 1
            ctl_pkg::AB_SP_INC:    ab_op = {7'b011_0001, abl_sel, 2'b00, abl_ci};
            ctl_pkg::AB_BRANCH:    ab_op = back ? `AB_OP_BRANCH_BACK : `AB_OP_BRANCH_FWD;
            ctl_pkg::AB_SP_KEEP:   ab_op = {7'b000_0001, abl_sel, 2'b00, abl_ci};
            ctl_pkg::AB_SP_SAVE:   ab_op = {7'b111_0001, abl_sel, 2'b00, abl_ci};  // Save PC + 1
            ctl_pkg::AB_ABS_KEEP:  ab_op = {7'b001_1110, abl_sel, 2'b01, abl_ci};
            ctl_pkg::AB_SP:        ab_op = {7'b010_0001, abl_sel, 2'b00, abl_ci};
            ctl_pkg::AB_NEXT_KEEP: ab_op = {7'b001_0110, abl_sel, 2'b11, abl_ci};
            ctl_pkg::AB_ABS_INC:   ab_op = {7'b001_1110, abl_sel, 2'b01, abl_ci};
            ctl_pkg::AB_VECTOR:    ab_op = {7'b000_0011, abl_sel, 2'b00, abl_ci};  // {FF, VEC} + 1
            default:               ab_op = '0;
        endcase
    end

endmodule

// ==== logic/ctl_top.sv ====
`timescale 1ns/1ps
`include "ctl_consts.svh"

module ctl_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cond,
    input  logic [`CTL_DB_W-1:0]      db,
    output logic                      sync,
    output logic                      we,
    output logic [`CTL_AB_OP_W-1:0]   ab_op,
    output logic [`CTL_REG_OP_W-1:0]  reg_op,
    output logic [`CTL_ALU_OP_W-1:0]  alu_op,
    output logic [`CTL_DO_OP_W-1:0]   do_op
);

    ctl_pkg::ctl_state_t state;
    ctl_pkg::reg_src_t   src;
    ctl_pkg::reg_dst_t   dst;
    ctl_pkg::alu_sel_t   alu;
    logic                addr_done;
    logic                rmw, jmp, ind;        // Sequencer branch flags
    logic                add_x, add_y, ld, st;

    cycle_sequencer i_cycle_sequencer (
        .clk(clk), .rst(rst), .db(db), .rmw(rmw), .jmp(jmp), .ind(ind),
        .state(state), .sync(sync), .we(we), .addr_done(addr_done)
    );

    opcode_decoder i_opcode_decoder (
        .clk(clk), .rst(rst), .db(db), .sync(sync), .addr_done(addr_done),
        .rmw(rmw), .jmp(jmp), .ind(ind), .add_x(add_x), .add_y(add_y),
        .ld(ld), .st(st), .src(src), .dst(dst), .alu(alu)
    );

    micro_op_encoder i_micro_op_encoder (
        .state(state), .ld(ld), .st(st), .add_x(add_x), .add_y(add_y),
        .src(src), .dst(dst), .alu(alu),
        .reg_op(reg_op), .alu_op(alu_op), .do_op(do_op)
    );

    addr_mode_encoder i_addr_mode_encoder (
        .state(state), .cond(cond), .db(db), .ab_op(ab_op)
    );

endmodule

// ==== dv/ctl_properties.sv ====
`timescale 1ns/1ps

module ctl_properties (
    input logic clk,
    input logic rst,
    input logic sync,
    input logic we
);

    // Fetch and memory write never share a cycle
    property sync_excludes_we;
        @(posedge clk) disable iff (rst) !(sync && we);
    endproperty

    // Sequencer parked in INIT while reset holds
    property no_sync_in_reset;
        @(posedge clk) rst |=> !sync;
    endproperty

    // Registered we still clear right after release
    property we_low_after_reset;
        @(posedge clk) $fell(rst) |-> !we;
    endproperty

    a_sync_excludes_we: assert property (sync_excludes_we)
        else $error("sync and we high in the same cycle");

    a_no_sync_in_reset: assert property (no_sync_in_reset)
        else $error("sync high while reset is applied");

    a_we_low_after_reset: assert property (we_low_after_reset)
        else $error("we high in the first cycle after reset");

endmodule

bind ctl_top ctl_properties i_ctl_properties (
    .clk(clk), .rst(rst), .sync(sync), .we(we)
);

// ==== dv/ctl_tb.sv ====
`timescale 1ns/1ps
`include "ctl_consts.svh"

module ctl_tb;

    localparam int        CLK_HALF   = 20;          // 40 ns period
    localparam int        DRIVE_DLY  = 2;           // Input skew after rising edge
    localparam int        NUM_ROWS   = 33;
    localparam int        MARGIN     = 20;          // Watchdog slack in cycles
    localparam logic [7:0] UNKNOWN_OP = 8'hEA;      // NOP is not decoded here

    typedef struct packed {
        logic [7:0] op;                             // Opcode at SYNC
        logic [3:0] len;                            // Cycles to next sync
        logic [1:0] writes;                         // Cycles with we high
        logic [6:0] reg_op;                         // At the following SYNC
        logic [8:0] alu_op;                         // At the following SYNC
        logic       cond;                           // Branch condition input
    } stim_row_t;

    logic                      clk;
    logic                      rst;
    logic                      cond;
    logic [`CTL_DB_W-1:0]      db;
    logic                      sync;
    logic                      we;
    logic [`CTL_AB_OP_W-1:0]   ab_op;
    logic [`CTL_REG_OP_W-1:0]  reg_op;
    logic [`CTL_ALU_OP_W-1:0]  alu_op;
    logic [`CTL_DO_OP_W-1:0]   do_op;

    integer seed;
    int     error_count;
    int     row_idx;
    int     cycle_count;

    // Expected reg_op as {write, dst, src} and alu_op as {00, shift, add, carry}
    stim_row_t stim_tab [NUM_ROWS] = '{
        {`OP_LDA_IMM,  4'd2, 2'd0, 7'h67, 9'h00C, 1'b0},   // A <= M
        {`OP_LDX_IMM,  4'd2, 2'd0, 7'h47, 9'h00C, 1'b0},   // X <= M
        {`OP_LDY_IMM,  4'd2, 2'd0, 7'h57, 9'h00C, 1'b0},   // Y <= M
        {`OP_LDA_ZP,   4'd3, 2'd0, 7'h67, 9'h00C, 1'b0},
        {`OP_LDA_ZPX,  4'd3, 2'd0, 7'h67, 9'h00C, 1'b0},
        {`OP_LDX_ZPY,  4'd3, 2'd0, 7'h47, 9'h00C, 1'b0},
        {`OP_LDA_ABS,  4'd4, 2'd0, 7'h67, 9'h00C, 1'b0},
        {`OP_LDA_ABSX, 4'd4, 2'd0, 7'h67, 9'h00C, 1'b0},   // No extra index cycle
        {`OP_LDA_ABSY, 4'd4, 2'd0, 7'h67, 9'h00C, 1'b0},
        {`OP_LDA_IND,  4'd5, 2'd0, 7'h67, 9'h00C, 1'b0},
        {`OP_LDA_INDX, 4'd5, 2'd0, 7'h67, 9'h00C, 1'b0},
        {`OP_LDA_INDY, 4'd5, 2'd0, 7'h67, 9'h00C, 1'b0},
        {`OP_INX,      4'd1, 2'd0, 7'h40, 9'h011, 1'b0},   // X + 1 in a single cycle
        {`OP_DEX,      4'd1, 2'd0, 7'h40, 9'h014, 1'b0},   // X - 1 in a single cycle
        {`OP_INC_ZP,   4'd4, 2'd1, 7'h25, 9'h011, 1'b0},
        {`OP_INC_ABS,  4'd5, 2'd1, 7'h25, 9'h011, 1'b0},
        {`OP_ASL_ZP,   4'd4, 2'd1, 7'h25, 9'h040, 1'b0},
        {`OP_ASL_ZPX,  4'd3, 2'd0, 7'h25, 9'h040, 1'b0},   // Short path without write
        {`OP_PHA,      4'd3, 2'd1, 7'h22, 9'h00C, 1'b0},
        {`OP_PLA,      4'd3, 2'd0, 7'h67, 9'h00C, 1'b0},
        {`OP_JMP_ABS,  4'd3, 2'd0, 7'h27, 9'h000, 1'b0},
        {`OP_JMP_IND,  4'd5, 2'd0, 7'h27, 9'h000, 1'b0},   // Two passes through ABS0
        {`OP_JMP_INDX, 4'd5, 2'd0, 7'h27, 9'h000, 1'b0},
        {`OP_JSR,      4'd5, 2'd2, 7'h27, 9'h000, 1'b0},   // PCH and PCL pushed
        {`OP_RTS,      4'd4, 2'd0, 7'h27, 9'h000, 1'b0},
        {`OP_BRK,      4'd7, 2'd3, 7'h27, 9'h000, 1'b0},   // PCH, PCL, P pushed
        {`OP_RTI,      4'd5, 2'd0, 7'h27, 9'h000, 1'b0},
        {`OP_BRA,      4'd2, 2'd0, 7'h27, 9'h000, 1'b1},
        {`OP_BRA,      4'd2, 2'd0, 7'h27, 9'h000, 1'b0},
        {`OP_BRA,      4'd2, 2'd0, 7'h27, 9'h000, 1'b1},
        {`OP_BRA,      4'd2, 2'd0, 7'h27, 9'h000, 1'b1},
        {UNKNOWN_OP,   4'd1, 2'd0, 7'h27, 9'h000, 1'b0},   // Stays in SYNC
        {`OP_LDA_IMM,  4'd2, 2'd0, 7'h67, 9'h00C, 1'b0}
    };

    ctl_top i_ctl_top (
        .clk(clk), .rst(rst), .cond(cond), .db(db), .sync(sync), .we(we),
        .ab_op(ab_op), .reg_op(reg_op), .alu_op(alu_op), .do_op(do_op)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Opcode on the bus in SYNC and noise otherwise
    task automatic advance_cycle(input logic [7:0] opcode, input logic cond_val);
        @(posedge clk);
        #DRIVE_DLY;
        if (sync)
            db = opcode;
        else
            db = $random(seed);
        cond = cond_val;
        @(negedge clk);                             // Outputs settled here
    endtask

    // Data out select for the n-th byte pushed by JSR or BRK
    function automatic logic [1:0] push_byte_sel(input int idx);
        case (idx)
            0:       return 2'b11;                  // PCH
            1:       return 2'b10;                  // PCL
            default: return 2'b01;                  // P
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_count++;
        $display("error at %0d ns: row %0d opcode %02h, %s is %0h, expected %0h",
                 $time, row_idx, stim_tab[row_idx].op, name, got, exp);
        $display("tests failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("at %0d ns: %s", $time, what);
        $display("tests failed");
        $fatal(1, "stopped at first failure");
    endtask

    initial begin : watchdog
        int limit;
        int i;
        limit = 3 + MARGIN;                         // Reset plus first fetch
        for (i = 0; i < NUM_ROWS; i++)
            limit += stim_tab[i].len;
        cycle_count = 0;
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        logic [`CTL_AB_OP_W-1:0] exp_ab;
        logic [`CTL_DO_OP_W-1:0] exp_do;
        logic [7:0]              next_op;
        logic                    pushes_pc;
        int                      len;
        int                      writes;
        seed        = 32'hb7d161b9;
        error_count = 0;
        rst         = 1'b1;
        cond        = 1'b0;
        db          = '0;

        @(posedge clk);                             // First reset edge
        #DRIVE_DLY;
        db = $random(seed);
        @(negedge clk);
        assert (!sync && !we) else report_failure("sync or we high during reset");
        @(posedge clk);                             // Second reset edge
        #DRIVE_DLY;
        rst = 1'b0;
        db  = $random(seed);
        @(negedge clk);
        assert (!sync && !we) else report_failure("sync or we high in the INIT cycle");
        advance_cycle(stim_tab[0].op, 1'b0);
        assert (sync) else report_failure("sync did not rise two cycles after reset");

        for (row_idx = 0; row_idx < NUM_ROWS; row_idx++) begin
            next_op   = (row_idx + 1 < NUM_ROWS) ? stim_tab[row_idx + 1].op : UNKNOWN_OP;
            pushes_pc = (stim_tab[row_idx].op == `OP_BRK) ||
                        (stim_tab[row_idx].op == `OP_JSR);
            len       = 0;
            writes    = 0;
            do begin
                advance_cycle(next_op, stim_tab[row_idx].cond);
                len++;
                // Return address and status bytes only in write cycles
                exp_do = (we && pushes_pc) ? push_byte_sel(writes) : 2'b00;
                assert (do_op == exp_do) else report_mismatch("do_op", do_op, exp_do);
                if (we)
                    writes++;
                // Offset sign on db in the COND cycle right after SYNC
                if (stim_tab[row_idx].op == `OP_BRA && len == 1) begin
                    exp_ab = (stim_tab[row_idx].cond && db[7]) ? `AB_OP_BRANCH_BACK
                                                                : `AB_OP_BRANCH_FWD;
                    assert (ab_op == exp_ab) else report_mismatch("ab_op", ab_op, exp_ab);
                end
            end while (!sync);
            assert (len == stim_tab[row_idx].len)
                else report_mismatch("cycles to sync", len, stim_tab[row_idx].len);
            assert (writes == stim_tab[row_idx].writes)
                else report_mismatch("we cycles", writes, stim_tab[row_idx].writes);
            assert (reg_op == stim_tab[row_idx].reg_op)   // Deferred write-back
                else report_mismatch("reg_op", reg_op, stim_tab[row_idx].reg_op);
            assert (alu_op == stim_tab[row_idx].alu_op)
                else report_mismatch("alu_op", alu_op, stim_tab[row_idx].alu_op);
        end

        if (error_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
logic/ctl_pkg.sv
logic/opcode_decoder.sv
logic/cycle_sequencer.sv
logic/micro_op_encoder.sv
logic/addr_mode_encoder.sv
logic/ctl_top.sv
dv/ctl_properties.sv
dv/ctl_tb.sv
